// File: vlane_alu_array.f
+incdir+.
vlane_pkg.sv
operand_gather.sv
element_alu.sv
result_scatter.sv
vlane_alu_array.sv
tb_vlane_alu_array.sv

// File: Bender.yml
package:
  name: vlane_alu_array

sources:
  - vlane_pkg.sv
  - operand_gather.sv
  - element_alu.sv
  - result_scatter.sv
  - vlane_alu_array.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vlane_alu_array.sv

// File: vlane_model.svh
////////////////////
// Vector lane ALU reference model
// Gather, lane ALU and scatter rules applied to whole port rows
////////////////////

`ifndef VLANE_MODEL_SVH
`define VLANE_MODEL_SVH

typedef logic [VLANE_NUM*32-1:0] row_t;     // All lane words of one port

// ALU input for one lane, byte k from byte e of lane b+k
function automatic word_t gather_ref(input row_t row, input sew_t sew, input int lane);
   word_t w;
   int g;
   int e;
   int b;
   g = (sew == SEW_32) ? 4 : ((sew == SEW_16) ? 2 : 1);
   e = lane % g;
   b = lane - e;
   w = '0;
   if (g == 1)
   begin
      w = row[lane*32 +: 32];                // Byte elements pass whole
   end
   else
   begin
      for (int k = 0; k < g; k++)
      begin
         w[8*k +: 8] = row[(b+k)*32 + 8*e +: 8];
      end
   end
   return w;
endfunction

function automatic word_t alu_ref(input word_t a, input word_t b, input alu_op_t op);
   case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      default: return a ^ b;
   endcase
endfunction

// Home lane word rebuilt from the ALU row
function automatic word_t scatter_ref(input row_t alu, input sew_t sew, input int lane);
   logic [15:0] half;
   int j;
   int b;
   case (sew)
      SEW_32:
      begin
         j = lane % 4;
         b = lane - j;
         return {alu[(b+3)*32 + 8*j +: 8], alu[(b+2)*32 + 8*j +: 8],
                 alu[(b+1)*32 + 8*j +: 8], alu[b*32 + 8*j +: 8]};
      end
      SEW_16:
      begin
         j    = lane % 2;
         b    = lane - j;
         half = {alu[(b+1)*32 + 8*j +: 8], alu[b*32 + 8*j +: 8]};
         return {half, half};
      end
      default: return {4{alu[lane*32 +: 8]}};
   endcase
endfunction

function automatic row_t expected_row(input row_t vs1, input row_t vs2, input sew_t sew,
                                      input alu_op_t op, input op2_src_t src,
                                      input word_t scalar, input imm_t imm);
   row_t  alu;
   row_t  out;
   word_t opb;
   for (int l = 0; l < VLANE_NUM; l++)
   begin
      case (src)
         SRC_SCALAR: opb = scalar;
         SRC_IMM:    opb = {27'd0, imm};
         default:    opb = gather_ref(vs2, sew, l);
      endcase
      alu[l*32 +: 32] = alu_ref(gather_ref(vs1, sew, l), opb, op);
   end
   for (int l = 0; l < VLANE_NUM; l++)
   begin
      out[l*32 +: 32] = scatter_ref(alu, sew, l);
   end
   return out;
endfunction

`endif

// File: tb_vlane_alu_array.sv
`timescale 1ns/10ps
////////////////////
// Vector lane ALU array testbench
// Seeded random issue on both ports, vector data three cycles
// later, results checked against the reference model
////////////////////

module tb_vlane_alu_array;
   import vlane_pkg::*;
   `include "vlane_model.svh"

   localparam int RES_LAT      = 5;     // DUT edges from issue to result
   localparam int PHASE_CYCLES = 40;
   localparam int NUM_PHASES   = 4;
   localparam int NUM_OPS      = PHASE_CYCLES * NUM_PHASES * PORT_NUM;
   localparam int DRAIN_CYCLES = 12;

   // Stimulus modes
   localparam int MODE_ARITH = 0;
   localparam int MODE_OPB   = 1;
   localparam int MODE_LOGIC = 2;
   localparam int MODE_BURST = 3;
   localparam int MODE_IDLE  = 4;

   logic                                clk_i = 1'b0;
   logic                                rst_i;
   logic     [PORT_NUM-1:0]             issue_i;
   sew_t     [PORT_NUM-1:0]             sew_i;
   alu_op_t  [PORT_NUM-1:0]             op_i;
   op2_src_t [PORT_NUM-1:0]             op2_src_i;
   word_t    [PORT_NUM-1:0]             scalar_i;
   imm_t     [PORT_NUM-1:0]             imm_i;
   word_t    [VLANE_NUM-1:0][PORT_NUM-1:0] vs1_i;
   word_t    [VLANE_NUM-1:0][PORT_NUM-1:0] vs2_i;
   word_t    [VLANE_NUM-1:0][PORT_NUM-1:0] res_o;
   logic     [PORT_NUM-1:0]             res_valid_o;

   int   seed = 85851;
   int   cyc;
   int   value_errors;
   int   strobe_errors;
   bit   checking;
   row_t vs1_buf [4][PORT_NUM];        // Vector data waiting for the register file delay
   row_t vs2_buf [4][PORT_NUM];
   int   due_q [PORT_NUM][$];
   row_t exp_q [PORT_NUM][$];

   vlane_alu_array dut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .issue_i     (issue_i),
      .sew_i       (sew_i),
      .op_i        (op_i),
      .op2_src_i   (op2_src_i),
      .scalar_i    (scalar_i),
      .imm_i       (imm_i),
      .vs1_i       (vs1_i),
      .vs2_i       (vs2_i),
      .res_o       (res_o),
      .res_valid_o (res_valid_o)
   );

   always #4 clk_i = ~clk_i;

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic alu_op_t pick_op(input int mode);
      case (mode)
         MODE_ARITH: return alu_op_t'(rand_below(2));      // Add or subtract
         MODE_LOGIC: return alu_op_t'(2 + rand_below(3));
         default:    return alu_op_t'(rand_below(5));
      endcase
   endfunction

   function automatic op2_src_t pick_src(input int mode);
      case (mode)
         MODE_ARITH: return SRC_VEC;
         MODE_OPB:   return op2_src_t'(1 + rand_below(2));  // Scalar or immediate
         default:    return op2_src_t'(rand_below(3));
      endcase
   endfunction

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic drive_cycle(input int mode);
      int       old;
      int       slot;
      bit       go;
      sew_t     s;
      alu_op_t  o;
      op2_src_t src;
      word_t    sc;
      imm_t     im;
      @(posedge clk_i);
      cyc++;
      old  = (cyc + 1) % 4;                      // Filled three cycles back
      slot = cyc % 4;
      for (int p = 0; p < PORT_NUM; p++)
      begin
         for (int l = 0; l < VLANE_NUM; l++)
         begin
            vs1_i[l][p] <= vs1_buf[old][p][l*32 +: 32];
            vs2_i[l][p] <= vs2_buf[old][p][l*32 +: 32];
            vs1_buf[slot][p][l*32 +: 32] = $random(seed);
            vs2_buf[slot][p][l*32 +: 32] = $random(seed);
         end
         go  = (mode == MODE_BURST) || (mode != MODE_IDLE && rand_below(4) != 0);
         s   = sew_t'(rand_below(3));
         o   = pick_op(mode);
         src = pick_src(mode);
         sc  = $random(seed);
         im  = imm_t'(rand_below(32));
         issue_i[p]   <= go;
         sew_i[p]     <= s;
         op_i[p]      <= o;
         op2_src_i[p] <= src;
         scalar_i[p]  <= sc;
         imm_i[p]     <= im;
         if (go)
         begin
            // One edge to reach the DUT, then the pipeline
            due_q[p].push_back(cyc + 1 + RES_LAT);
            exp_q[p].push_back(expected_row(vs1_buf[slot][p], vs2_buf[slot][p],
                                            s, o, src, sc, im));
         end
      end
   endtask

   task automatic run_phase(input int mode, input int n);
      repeat (n)
      begin
         drive_cycle(mode);
      end
   endtask

   ////////////////////
   // Checking
   ////////////////////

   task automatic compare_row(input int p, input row_t exp);
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         assert (res_o[l][p] === exp[l*32 +: 32])
         else
         begin
            value_errors++;
            $display("Fail at %0t: res_o[%0d][%0d] expected %h, got %h",
                     $time, l, p, exp[l*32 +: 32], res_o[l][p]);
         end
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk_i)
   begin
      bit due;
      if (checking)
      begin
         for (int p = 0; p < PORT_NUM; p++)
         begin
            due = (due_q[p].size() > 0) && (due_q[p][0] == cyc);
            assert (res_valid_o[p] === due)
            else
            begin
               strobe_errors++;
               if (due)
                  $display("Result missing on port %0d at %0t", p, $time);
               else
                  $display("Unexpected res_valid_o on port %0d at %0t", p, $time);
            end
            if (due)
            begin
               if (res_valid_o[p] === 1'b1)
                  compare_row(p, exp_q[p][0]);
               void'(exp_q[p].pop_front());
               void'(due_q[p].pop_front());
            end
         end
      end
   end

   initial
   begin
      #((NUM_OPS * 8 + 100) * 8);
      $display("Watchdog expired before the test sequence finished");
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      rst_i    = 1'b0;
      issue_i  = '0;
      scalar_i = '0;
      imm_i    = '0;
      vs1_i    = '0;
      vs2_i    = '0;
      for (int p = 0; p < PORT_NUM; p++)
      begin
         sew_i[p]     = SEW_8;
         op_i[p]      = OP_ADD;
         op2_src_i[p] = SRC_VEC;
         for (int s = 0; s < 4; s++)
         begin
            vs1_buf[s][p] = '0;
            vs2_buf[s][p] = '0;
         end
      end
      cyc           = 0;
      value_errors  = 0;
      strobe_errors = 0;
      checking      = 1'b0;

      repeat (3) @(posedge clk_i);
      rst_i <= 1'b1;
      @(negedge clk_i);
      assert (res_valid_o === '0)
      else
      begin
         strobe_errors++;
         $display("res_valid_o not low after reset at %0t", $time);
      end
      checking = 1'b1;

      run_phase(MODE_ARITH, PHASE_CYCLES);
      run_phase(MODE_OPB, PHASE_CYCLES);
      run_phase(MODE_LOGIC, PHASE_CYCLES);
      run_phase(MODE_BURST, PHASE_CYCLES);
      run_phase(MODE_IDLE, DRAIN_CYCLES);        // Let the pipeline empty
      @(negedge clk_i);
      #1;

      $display("Errors: %0d value, %0d strobe", value_errors, strobe_errors);
      if (value_errors == 0 && strobe_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: vlane_alu_array.sv
`timescale 1ns/10ps
////////////////////
// Vector lane ALU array
// SIMD arithmetic path for eight lanes and two issue ports
// Decode, execute and result stages, five cycles issue to result
////////////////////

module vlane_alu_array (
   input  logic                                                        clk_i,
   input  logic                                                        rst_i,
   input  logic [vlane_pkg::PORT_NUM-1:0]                              issue_i,
   input  vlane_pkg::sew_t [vlane_pkg::PORT_NUM-1:0]                   sew_i,
   input  vlane_pkg::alu_op_t [vlane_pkg::PORT_NUM-1:0]                op_i,
   input  vlane_pkg::op2_src_t [vlane_pkg::PORT_NUM-1:0]               op2_src_i,
   input  vlane_pkg::word_t [vlane_pkg::PORT_NUM-1:0]                  scalar_i,
   input  vlane_pkg::imm_t [vlane_pkg::PORT_NUM-1:0]                   imm_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] vs1_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] vs2_i,
   output vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] res_o,
   output logic [vlane_pkg::PORT_NUM-1:0]                              res_valid_o
);
   import vlane_pkg::*;

   // Decode to execute
   word_t   [VLANE_NUM-1:0][PORT_NUM-1:0] opa;
   word_t   [VLANE_NUM-1:0][PORT_NUM-1:0] opb;
   alu_op_t [PORT_NUM-1:0]                op_dec;
   sew_t    [PORT_NUM-1:0]                sew_dec;
   logic    [PORT_NUM-1:0]                valid_dec;

   // Execute to result
   word_t   [VLANE_NUM-1:0][PORT_NUM-1:0] alu_res;
   sew_t    [PORT_NUM-1:0]                sew_exe;
   logic    [PORT_NUM-1:0]                valid_exe;

   operand_gather u_gather (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .issue_i   (issue_i),
      .sew_i     (sew_i),
      .op_i      (op_i),
      .op2_src_i (op2_src_i),
      .scalar_i  (scalar_i),
      .imm_i     (imm_i),
      .vs1_i     (vs1_i),
      .vs2_i     (vs2_i),
      .opa_o     (opa),
      .opb_o     (opb),
      .op_o      (op_dec),
      .sew_o     (sew_dec),
      .valid_o   (valid_dec)
   );

   element_alu u_alu (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .opa_i   (opa),
      .opb_i   (opb),
      .op_i    (op_dec),
      .sew_i   (sew_dec),
      .valid_i (valid_dec),
      .res_o   (alu_res),
      .sew_o   (sew_exe),
      .valid_o (valid_exe)
   );

   result_scatter u_scatter (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .res_i       (alu_res),
      .sew_i       (sew_exe),
      .valid_i     (valid_exe),
      .res_o       (res_o),
      .res_valid_o (res_valid_o)
   );

endmodule

// File: result_scatter.sv
`timescale 1ns/10ps
////////////////////
// Result scatter
// Result stage. Returns the ALU result bytes of each group of four
// lanes to their home lanes and registers the lane words
////////////////////

module result_scatter (
   input  logic                                                        clk_i,
   input  logic                                                        rst_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] res_i,
   input  vlane_pkg::sew_t [vlane_pkg::PORT_NUM-1:0]                   sew_i,
   input  logic [vlane_pkg::PORT_NUM-1:0]                              valid_i,
   output vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] res_o,
   output logic [vlane_pkg::PORT_NUM-1:0]                              res_valid_o
);
   import vlane_pkg::*;

   word_t [VLANE_NUM-1:0][PORT_NUM-1:0] lane_d;

   ////////////////////
   // Byte scatter
   ////////////////////

   always_comb
   begin
      byte_t [BYTES_PER_WORD-1:0] gath;
      int pair;
      for (int b = 0; b < VLANE_NUM; b += BYTES_PER_WORD)
      begin
         for (int p = 0; p < PORT_NUM; p++)
         begin
            for (int j = 0; j < BYTES_PER_WORD; j++)
            begin
               pair = b + j - (j % 2);                // First lane of the 16 bit pair
               case (sew_i[p])
                  SEW_32:
                  begin
                     // Byte j of every ALU in the group, ALU b+3 on top
                     for (int k = 0; k < BYTES_PER_WORD; k++)
                     begin
                        gath[k] = res_i[b+k][p][8*j +: 8];
                     end
                  end
                  SEW_16:
                  begin
                     gath[0] = res_i[pair][p][8*(j%2) +: 8];
                     gath[1] = res_i[pair+1][p][8*(j%2) +: 8];
                     gath[2] = gath[0];               // Half repeated upward
                     gath[3] = gath[1];
                  end
                  default: gath = {4{res_i[b+j][p][7:0]}};
               endcase
               lane_d[b+j][p] = gath;
            end
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      res_o <= lane_d;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         res_valid_o <= '0;
      end
      else
      begin
         res_valid_o <= valid_i;
      end
   end

   // Result strobe stays known once out of reset
   a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_i)
      !$isunknown(res_valid_o));

endmodule

// File: element_alu.sv
`timescale 1ns/10ps
////////////////////
// Element ALU
// Execute stage. One registered 32 bit ALU per lane and port,
// with the width and valid tags carried one stage along
////////////////////

module element_alu (
   input  logic                                                        clk_i,
   input  logic                                                        rst_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] opa_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] opb_i,
   input  vlane_pkg::alu_op_t [vlane_pkg::PORT_NUM-1:0]                op_i,
   input  vlane_pkg::sew_t [vlane_pkg::PORT_NUM-1:0]                   sew_i,
   input  logic [vlane_pkg::PORT_NUM-1:0]                              valid_i,
   output vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] res_o,
   output vlane_pkg::sew_t [vlane_pkg::PORT_NUM-1:0]                   sew_o,
   output logic [vlane_pkg::PORT_NUM-1:0]                              valid_o
);
   import vlane_pkg::*;

   ////////////////////
   // Lane ALUs
   ////////////////////

   // Full 32 bit operation for every width
   // Carries past the element width land in bytes the scatter drops
   always_ff @(posedge clk_i)
   begin
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         for (int p = 0; p < PORT_NUM; p++)
         begin
            case (op_i[p])
               OP_ADD:  res_o[l][p] <= opa_i[l][p] + opb_i[l][p];
               OP_SUB:  res_o[l][p] <= opa_i[l][p] - opb_i[l][p];
               OP_AND:  res_o[l][p] <= opa_i[l][p] & opb_i[l][p];
               OP_OR:   res_o[l][p] <= opa_i[l][p] | opb_i[l][p];
               OP_XOR:  res_o[l][p] <= opa_i[l][p] ^ opb_i[l][p];
               default: res_o[l][p] <= '0;            // Unused opcode
            endcase
         end
      end
      sew_o <= sew_i;                                 // Width tag for the scatter
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         valid_o <= '0;
      end
      else
      begin
         valid_o <= valid_i;
      end
   end

   // A result tagged valid carries no unknown bits
   for (genvar gl = 0; gl < VLANE_NUM; gl++)
   begin : g_lane_chk
      for (genvar gp = 0; gp < PORT_NUM; gp++)
      begin : g_port_chk
         a_res_known: assert property (@(posedge clk_i) disable iff (!rst_i)
            valid_o[gp] |-> !$isunknown(res_o[gl][gp]));
      end
   end

endmodule

// File: operand_gather.sv
`timescale 1ns/10ps
////////////////////
// Operand gather
// Decode stage of the lane array. Holds the issue controls until the
// register file data arrives, packs cross-lane elements for 16 and
// 32 bit widths and picks the second ALU operand
////////////////////

module operand_gather (
   input  logic                                                        clk_i,
   input  logic                                                        rst_i,
   input  logic [vlane_pkg::PORT_NUM-1:0]                              issue_i,
   input  vlane_pkg::sew_t [vlane_pkg::PORT_NUM-1:0]                   sew_i,
   input  vlane_pkg::alu_op_t [vlane_pkg::PORT_NUM-1:0]                op_i,
   input  vlane_pkg::op2_src_t [vlane_pkg::PORT_NUM-1:0]               op2_src_i,
   input  vlane_pkg::word_t [vlane_pkg::PORT_NUM-1:0]                  scalar_i,
   input  vlane_pkg::imm_t [vlane_pkg::PORT_NUM-1:0]                   imm_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] vs1_i,
   input  vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] vs2_i,
   output vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] opa_o,
   output vlane_pkg::word_t [vlane_pkg::VLANE_NUM-1:0][vlane_pkg::PORT_NUM-1:0] opb_o,
   output vlane_pkg::alu_op_t [vlane_pkg::PORT_NUM-1:0]                op_o,
   output vlane_pkg::sew_t [vlane_pkg::PORT_NUM-1:0]                   sew_o,
   output logic [vlane_pkg::PORT_NUM-1:0]                              valid_o
);
   import vlane_pkg::*;

   // Issue control delay line, last stage lines up with vs1_i and vs2_i
   logic     [PORT_NUM-1:0][VRF_DELAY-1:0] vld_dly;
   sew_t     [PORT_NUM-1:0][VRF_DELAY-1:0] sew_dly;
   alu_op_t  [PORT_NUM-1:0][VRF_DELAY-1:0] op_dly;
   op2_src_t [PORT_NUM-1:0][VRF_DELAY-1:0] src_dly;
   word_t    [PORT_NUM-1:0][VRF_DELAY-1:0] scalar_dly;
   imm_t     [PORT_NUM-1:0][VRF_DELAY-1:0] imm_dly;

   word_t [VLANE_NUM-1:0][PORT_NUM-1:0] opa_d;
   word_t [VLANE_NUM-1:0][PORT_NUM-1:0] opb_d;

   // Element for one ALU: byte k comes from byte e of lane base+k
   function automatic word_t gather_elem(input word_t [VLANE_NUM-1:0][PORT_NUM-1:0] vs,
                                         input sew_t sew, input int lane, input int port);
      byte_t [BYTES_PER_WORD-1:0] elem;
      int base;
      int idx;
      elem = '0;
      case (sew)
         SEW_32:
         begin
            idx  = lane % 4;
            base = lane - idx;
            for (int k = 0; k < 4; k++)
            begin
               elem[k] = vs[base+k][port][8*idx +: 8];
            end
         end
         SEW_16:
         begin
            idx  = lane % 2;
            base = lane - idx;
            for (int k = 0; k < 2; k++)
            begin
               elem[k] = vs[base+k][port][8*idx +: 8];
            end
         end
         default: elem = vs[lane][port];   // Byte elements stay in place
      endcase
      return elem;
   endfunction

   ////////////////////
   // Control delay
   ////////////////////

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         vld_dly <= '0;
      end
      else
      begin
         for (int p = 0; p < PORT_NUM; p++)
         begin
            vld_dly[p][0] <= issue_i[p];
            for (int s = 1; s < VRF_DELAY; s++)
            begin
               vld_dly[p][s] <= vld_dly[p][s-1];
            end
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int p = 0; p < PORT_NUM; p++)
      begin
         sew_dly[p][0]    <= sew_i[p];
         op_dly[p][0]     <= op_i[p];
         src_dly[p][0]    <= op2_src_i[p];
         scalar_dly[p][0] <= scalar_i[p];
         imm_dly[p][0]    <= imm_i[p];
         for (int s = 1; s < VRF_DELAY; s++)
         begin
            sew_dly[p][s]    <= sew_dly[p][s-1];
            op_dly[p][s]     <= op_dly[p][s-1];
            src_dly[p][s]    <= src_dly[p][s-1];
            scalar_dly[p][s] <= scalar_dly[p][s-1];
            imm_dly[p][s]    <= imm_dly[p][s-1];
         end
      end
   end

   ////////////////////
   // Gather and op2 select
   ////////////////////

   always_comb
   begin
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         for (int p = 0; p < PORT_NUM; p++)
         begin
            opa_d[l][p] = gather_elem(vs1_i, sew_dly[p][VRF_DELAY-1], l, p);
            case (src_dly[p][VRF_DELAY-1])
               SRC_SCALAR: opb_d[l][p] = scalar_dly[p][VRF_DELAY-1];
               SRC_IMM:    opb_d[l][p] = word_t'(imm_dly[p][VRF_DELAY-1]);
               default:    opb_d[l][p] = gather_elem(vs2_i, sew_dly[p][VRF_DELAY-1], l, p);
            endcase
         end
      end
   end

   // Operand register
   always_ff @(posedge clk_i)
   begin
      opa_o <= opa_d;
      opb_o <= opb_d;
      for (int p = 0; p < PORT_NUM; p++)
      begin
         op_o[p]  <= op_dly[p][VRF_DELAY-1];
         sew_o[p] <= sew_dly[p][VRF_DELAY-1];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         valid_o <= '0;
      end
      else
      begin
         for (int p = 0; p < PORT_NUM; p++)
         begin
            valid_o[p] <= vld_dly[p][VRF_DELAY-1];
         end
      end
   end

   // Issue never carries the dropped reduction source or unused codes
   for (genvar gp = 0; gp < PORT_NUM; gp++)
   begin : g_issue_chk
      a_issue_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
         issue_i[gp] |-> (op2_src_i[gp] != 2'd3 && sew_i[gp] != 2'd3 && op_i[gp] <= OP_XOR));
   end

endmodule

// File: vlane_pkg.sv
////////////////////
// Vector lane ALU package
// Lane and port counts, register file latency and the shared
// word, byte, width and opcode types of the SIMD arithmetic path
////////////////////

package vlane_pkg;

   ////////////////////
   // Array dimensions
   ////////////////////

   // Lane count, kept a multiple of four for the 32 bit groups
   localparam int VLANE_NUM = 8;

   localparam int PORT_NUM = 2;        // Parallel issue ports

   // Cycles from issue to vector source data
   localparam int VRF_DELAY = 3;

   localparam int BYTES_PER_WORD = 4;  // Also the widest lane group

   ////////////////////
   // Data types
   ////////////////////

   typedef logic [31:0] word_t;        // One lane word
   typedef logic [7:0]  byte_t;        // One element byte
   typedef logic [4:0]  imm_t;         // Zero-extended when used

   // Element width, code 3 never issued
   typedef enum logic [1:0]
   {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } sew_t;

   // ALU operation, codes 5 to 7 unused
   typedef enum logic [2:0]
   {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4
   } alu_op_t;

   // Second operand source
   typedef enum logic [1:0]
   {
      SRC_VEC    = 2'd0,       // Gathered vs2 element
      SRC_SCALAR = 2'd1,       // Scalar word broadcast to all lanes
      SRC_IMM    = 2'd2        // Immediate, zero-extended
   } op2_src_t;

endpackage
